// File: build.sh
#!/bin/sh
# Compile and run the queued scratchpad testbench with Verilator
# Pass or fail is read back from the simulation log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module mem_queue_tb \
  -f mem_queue_top.f \
  -o mem_queue_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mem_queue_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation completed successfully" "$log"; then
  exit 0
fi
exit 1

// File: design/fifo.sv
//--------------------------------------------------
// Pointer-based FIFO with combinational head read
// Depth must be a power of two
// Caller keeps push off while full, pop off while empty
//--------------------------------------------------

`timescale 1ns/1ps

module fifo #(
  parameter int entry_bits = 32,
  parameter int depth      = 8
) (
  input  logic   clk,
  input  logic   rst,
  fifo_if.storage q
);

  //--------------------------------------------------
  // Pointers
  //--------------------------------------------------

  // Index width
  // Pointers carry one extra wrap bit
  localparam int ptr_bits = $clog2(depth);

  logic [ptr_bits:0] wptr;
  logic [ptr_bits:0] rptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      // Advance on each strobe
      if (q.push) begin
        wptr <= wptr + 1'b1;
      end
      if (q.pop) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  // Equal pointers, nothing stored
  assign q.empty = (wptr == rptr);

  //--------------------------------------------------
  // Storage
  //--------------------------------------------------

  generate
    if (depth == 1) begin : g_single
      logic [entry_bits-1:0] arr;

      // Single slot, wrap bit alone tells full
      assign q.full = (wptr != rptr);

      always_ff @(posedge clk) begin
        if (rst) begin
          arr <= '0;
        end else if (q.push) begin
          arr <= q.wdata;
        end
      end

      // Head is the only slot
      assign q.rdata = arr;

    end else begin : g_array
      logic [entry_bits-1:0] arr [depth];

      // Same slot index, opposite wrap bit
      assign q.full = (wptr[ptr_bits-1:0] == rptr[ptr_bits-1:0])
                    & (wptr[ptr_bits] != rptr[ptr_bits]);

      always_ff @(posedge clk) begin
        if (rst) begin
          arr <= '{default: '0};
        end else if (q.push) begin
          // Write at tail slot
          arr[wptr[ptr_bits-1:0]] <= q.wdata;
        end
      end

      // Head slot shown without a register stage
      assign q.rdata = arr[rptr[ptr_bits-1:0]];
    end
  endgenerate

endmodule

// File: design/fifo_if.sv
//--------------------------------------------------
// Push/pop bundle of one FIFO
// storage goes on the fifo, producer on the writer,
// consumer on the reader
//--------------------------------------------------

`timescale 1ns/1ps

interface fifo_if #(
  parameter int width = 32
);

  // Strobes and status
  logic             push;
  logic             pop;
  logic             empty;
  logic             full;

  // Entry in and head entry out
  logic [width-1:0] wdata;
  logic [width-1:0] rdata;

  modport storage  (input push, input pop, input wdata, output empty, output full, output rdata);
  modport producer (output push, output wdata, input full);
  modport consumer (output pop, input empty, input rdata);

endinterface

// File: design/mem_queue_top.sv
//--------------------------------------------------
// Queued scratchpad memory, top level
// Producer pushes requests on req_*, consumer pops
// read responses on resp_*
//--------------------------------------------------

`timescale 1ns/1ps

module mem_queue_top (
  input  logic                 clk,
  input  logic                 rst,

  // Request side
  input  logic                 req_push,
  input  logic                 req_write,
  input  mem_types_pkg::addr_t req_addr,
  input  mem_types_pkg::data_t req_wdata,
  output logic                 req_full,

  // Response side
  input  logic                 resp_pop,
  output logic                 resp_empty,
  output mem_types_pkg::data_t resp_rdata
);

  import mem_types_pkg::*;
  import queue_cfg_pkg::*;

  //--------------------------------------------------
  // Queue bundles
  //--------------------------------------------------

  fifo_if #(.width(req_bits))  req_q ();
  fifo_if #(.width(data_bits)) resp_q ();

  // Producer side of the request queue
  assign req_q.push  = req_push;
  // Flag, address, data from the top
  assign req_q.wdata = {req_write, req_addr, req_wdata};
  assign req_full    = req_q.full;

  // Consumer side of the response queue
  assign resp_q.pop  = resp_pop;
  assign resp_empty  = resp_q.empty;
  assign resp_rdata  = resp_q.rdata;

  //--------------------------------------------------
  // Request FIFO
  //--------------------------------------------------

  fifo #(
    .entry_bits (req_bits),
    .depth      (req_depth)
  ) req_fifo (
    .clk (clk),
    .rst (rst),
    .q   (req_q)
  );

  //--------------------------------------------------
  // Engine
  //--------------------------------------------------

  scratchpad_engine engine (
    .clk  (clk),
    .rst  (rst),
    .req  (req_q),
    .resp (resp_q)
  );

  //--------------------------------------------------
  // Response FIFO
  //--------------------------------------------------

  fifo #(
    .entry_bits (data_bits),
    .depth      (resp_depth)
  ) resp_fifo (
    .clk (clk),
    .rst (rst),
    .q   (resp_q)
  );

endmodule

// File: design/mem_types_pkg.sv
//--------------------------------------------------
// Widths and vector types for scratchpad requests
// Import wherever addresses, data words or packed
// request entries are handled
//--------------------------------------------------

package mem_types_pkg;

  // Word address into the scratchpad
  localparam int addr_bits = 6;

  // Read and write data word
  localparam int data_bits = 32;

  // Packed request entry
  // Write flag on top, then address, then data
  localparam int req_bits = 1 + addr_bits + data_bits;

  // Scratchpad word address
  typedef logic [addr_bits-1:0] addr_t;

  // Data word, read or write
  typedef logic [data_bits-1:0] data_t;

  // One request as held in the request FIFO
  typedef logic [req_bits-1:0] req_t;

endpackage

// File: design/queue_cfg_pkg.sv
//--------------------------------------------------
// Sizing of the two queues and the scratchpad
// Import where FIFO depths or memory size are needed
//--------------------------------------------------

package queue_cfg_pkg;

  // Request FIFO entries, power of two only
  localparam int req_depth = 8;

  // Response FIFO entries, power of two only
  localparam int resp_depth = 4;

  // Scratchpad words
  // One word per address value
  localparam int spad_words = 2 ** mem_types_pkg::addr_bits;

endpackage

// File: design/scratchpad_engine.sv
//--------------------------------------------------
// In-order request engine around the scratchpad
// Pops packed requests, runs them through two stages,
// and pushes one response word for every read
//--------------------------------------------------

`timescale 1ns/1ps

module scratchpad_engine (
  input  logic     clk,
  input  logic     rst,
  fifo_if.consumer req,
  fifo_if.producer resp
);

  import mem_types_pkg::*;
  import queue_cfg_pkg::*;

  //--------------------------------------------------
  // Request unpack
  //--------------------------------------------------

  req_t  head;
  logic  head_write;
  addr_t head_addr;
  data_t head_data;

  assign head       = req.rdata;
  // Write flag on top
  assign head_write = head[req_bits-1];
  // Address below the flag
  assign head_addr  = head[req_bits-2 -: addr_bits];
  // Data in the low bits
  assign head_data  = head[data_bits-1:0];

  //--------------------------------------------------
  // Stage control
  //--------------------------------------------------

  logic  s1_valid;
  logic  s1_write;
  addr_t s1_addr;
  data_t s1_data;

  logic  s2_valid;
  logic  s2_write;
  addr_t s2_addr;
  data_t s2_data;

  logic  s2_retire;
  logic  s2_accept;
  logic  s1_advance;
  logic  s1_ready;

  // Writes always retire, reads need response room
  assign s2_retire  = s2_valid & (s2_write | ~resp.full);
  // Stage 2 takes new work when empty or leaving
  assign s2_accept  = ~s2_valid | s2_retire;
  assign s1_advance = s1_valid & s2_accept;
  // Stage 1 free, or handing over this cycle
  assign s1_ready   = ~s1_valid | s1_advance;

  // Pop whenever there is a request and somewhere to put it
  assign req.pop = ~req.empty & s1_ready;

  //--------------------------------------------------
  // Stage 1 registers
  //--------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= req.pop;
    end
  end

  // Payload loads only on a pop
  always_ff @(posedge clk) begin
    if (req.pop) begin
      s1_write <= head_write;
      s1_addr  <= head_addr;
      s1_data  <= head_data;
    end
  end

  //--------------------------------------------------
  // Stage 2 registers
  //--------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else if (s2_accept) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_advance) begin
      s2_write <= s1_write;
      s2_addr  <= s1_addr;
      s2_data  <= s1_data;
    end
  end

  //--------------------------------------------------
  // Scratchpad and response
  //--------------------------------------------------

  data_t spad [spad_words];

  // Comes up all zeros
  always_ff @(posedge clk) begin
    if (rst) begin
      spad <= '{default: '0};
    end else if (s2_retire && s2_write) begin
      spad[s2_addr] <= s2_data;
    end
  end

  // Read retire pushes the addressed word
  // Earlier writes have already landed, so order holds
  assign resp.push  = s2_valid & ~s2_write & ~resp.full;
  assign resp.wdata = spad[s2_addr];

endmodule

// File: mem_queue_top.f
design/mem_types_pkg.sv
design/queue_cfg_pkg.sv
design/fifo_if.sv
design/fifo.sv
design/scratchpad_engine.sv
design/mem_queue_top.sv
testbench/mem_queue_tb.sv

// File: testbench/mem_queue_tb.sv
//--------------------------------------------------
// Testbench for the queued scratchpad memory
// Pushes requests, pops responses and checks them
// against a reference model
// Run with build.sh
//--------------------------------------------------

`timescale 1ns/1ps

module mem_queue_tb;

  import mem_types_pkg::*;
  import queue_cfg_pkg::*;

  logic  clk;
  logic  rst;
  logic  req_push;
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;
  logic  req_full;
  logic  resp_pop;
  logic  resp_empty;
  data_t resp_rdata;

  // Reference scratchpad and the expected read data in order
  data_t       model [spad_words];
  data_t       exp_q [$];
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          reads_owed;
  logic [31:0] lfsr_state;

  mem_queue_top DUT (
    .clk        (clk),
    .rst        (rst),
    .req_push   (req_push),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_full   (req_full),
    .resp_pop   (resp_pop),
    .resp_empty (resp_empty),
    .resp_rdata (resp_rdata)
  );

  // 8 ns period
  always #4 clk = ~clk;

  //--------------------------------------------------
  // Outstanding reads and the response queue
  //--------------------------------------------------

  // Reads pushed minus responses popped
  always @(posedge clk) begin
    if (rst) begin
      reads_owed <= 0;
    end else begin
      reads_owed <= reads_owed + ((req_push && !req_write) ? 1 : 0) - (resp_pop ? 1 : 0);
    end
  end

  // No response without a read behind it
  owed_check: assert property (@(posedge clk) disable iff (rst) !resp_empty |-> reads_owed > 0)
    else begin
      errors++;
      $display("response present with no read outstanding");
    end

  //--------------------------------------------------
  // Random source
  //--------------------------------------------------

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  //--------------------------------------------------
  // Checks and reporting
  //--------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      errors++;
      $display("mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    if (errors == errs_at_start) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - errs_at_start);
    end
  endtask

  //--------------------------------------------------
  // Stimulus
  //--------------------------------------------------

  // One clock of stimulus entered 1 ns after an edge
  task automatic run_cycle(input logic push, input logic wr, input addr_t a, input data_t d,
                           input logic pop);
    data_t expected;
    req_push  = push;
    req_write = wr;
    req_addr  = a;
    req_wdata = d;
    resp_pop  = pop;
    // Head is checked before it leaves
    if (pop) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("response popped while no read was expected");
      end else begin
        expected = exp_q.pop_front();
        check_value("resp_rdata", expected, resp_rdata);
      end
    end
    // Model runs in request order
    if (push) begin
      if (wr) begin
        model[a] = d;
      end else begin
        exp_q.push_back(model[a]);
      end
    end
    @(posedge clk);
    #1;
    req_push = 1'b0;
    resp_pop = 1'b0;
  endtask

  task automatic idle_cycle();
    run_cycle(1'b0, 1'b0, '0, '0, 1'b0);
  endtask

  // Holds off while the request FIFO is full
  task automatic push_req(input logic wr, input addr_t a, input data_t d);
    int waited;
    waited = 0;
    while (req_full) begin
      if (waited >= 50) begin
        report_timeout("req_full to clear");
        return;
      end
      idle_cycle();
      waited++;
    end
    run_cycle(1'b1, wr, a, d, 1'b0);
  endtask

  // Pops until every expected read has come back
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() > 0) begin
      if (waited >= 200) begin
        report_timeout("the expected responses");
        return;
      end
      run_cycle(1'b0, 1'b0, '0, '0, !resp_empty);
      waited++;
    end
  endtask

  //--------------------------------------------------
  // Test sequence
  //--------------------------------------------------

  initial begin
    int    errs;
    int    lat;
    int    pushes;
    int    cycles;
    logic  do_push;
    logic  do_pop;
    logic  wr;
    addr_t a;
    data_t d;

    clk          = 1'b0;
    rst          = 1'b1;
    req_push     = 1'b0;
    req_write    = 1'b0;
    req_addr     = '0;
    req_wdata    = '0;
    resp_pop     = 1'b0;
    lfsr_state   = 32'd75065;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Untouched words read zero after reset
    errs = errors;
    check_value("resp_empty", 32'd1, 32'(resp_empty));
    check_value("req_full", 32'd0, 32'(req_full));
    push_req(1'b0, 6'd0, '0);
    push_req(1'b0, 6'd63, '0);
    push_req(1'b0, addr_t'(rand_bits(addr_bits)), '0);
    drain();
    end_test("reset state", errs);

    // Writes with one overwrite and the reads back
    errs = errors;
    push_req(1'b1, 6'd3, rand_bits(data_bits));
    push_req(1'b1, 6'd17, rand_bits(data_bits));
    push_req(1'b1, 6'd40, rand_bits(data_bits));
    push_req(1'b1, 6'd3, rand_bits(data_bits));
    push_req(1'b0, 6'd40, '0);
    push_req(1'b0, 6'd3, '0);
    push_req(1'b0, 6'd17, '0);
    drain();
    end_test("write then read", errs);

    // Idle read shows up three edges after the push edge
    errs = errors;
    push_req(1'b0, 6'd17, '0);
    lat = 0;
    while (resp_empty) begin
      if (lat >= 20) begin
        report_timeout("resp_empty to fall");
        break;
      end
      idle_cycle();
      lat++;
    end
    check_value("latency", 32'd3, 32'(lat));
    drain();
    end_test("idle latency", errs);

    // Distinct words at the addresses read below
    errs = errors;
    for (int i = 0; i < 14; i++) begin
      push_req(1'b1, addr_t'(i), rand_bits(data_bits));
    end
    // This read returns only after every write ahead of it
    push_req(1'b0, 6'd0, '0);
    drain();
    // Only reads and no pops until the request FIFO fills
    pushes = 0;
    while (!req_full) begin
      if (pushes >= 40) begin
        report_timeout("req_full to rise");
        break;
      end
      run_cycle(1'b1, 1'b0, addr_t'(pushes), '0, 1'b0);
      pushes++;
    end
    check_value("push count", 32'd14, 32'(pushes));
    drain();
    end_test("back-pressure capacity", errs);

    // Mixed traffic with pushes on three cycles in four and pops on half
    errs = errors;
    pushes = 0;
    cycles = 0;
    while (pushes < 400) begin
      if (cycles >= 5000) begin
        report_timeout("random traffic to finish");
        break;
      end
      do_push = (rand_bits(2) != 0) && !req_full;
      wr      = rand_bits(1) != 0;
      a       = addr_t'(rand_bits(addr_bits));
      d       = rand_bits(data_bits);
      do_pop  = (rand_bits(1) != 0) && !resp_empty;
      run_cycle(do_push, wr, a, d, do_pop);
      if (do_push) begin
        pushes++;
      end
      cycles++;
    end
    drain();
    check_value("resp_empty", 32'd1, 32'(resp_empty));
    end_test("random traffic", errs);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
